/* src/emesh_pkg.sv */
`default_nettype none

package emesh_pkg;

   localparam int PW = 104;                  // Full packet width

   // Field positions, LSB upward
   localparam int CMD_LSB      = 0;
   localparam int CMD_W        = 2;
   localparam int DATAMODE_LSB = 2;
   localparam int DATAMODE_W   = 2;
   localparam int CTRLMODE_LSB = 4;
   localparam int CTRLMODE_W   = 4;
   localparam int DSTADDR_LSB  = 8;
   localparam int DSTADDR_W    = 32;
   localparam int DATA_LSB     = 40;
   localparam int DATA_W       = 32;
   localparam int SRCADDR_LSB  = 72;
   localparam int SRCADDR_W    = 32;

   typedef enum logic [1:0] {
      cmd_write = 2'd0,                      // Posted write
      cmd_read  = 2'd1,                      // Read request
      cmd_resp  = 2'd2,                      // Read response
      cmd_rsvd  = 2'd3                       // Unused, dropped
   } cmd_t;

   typedef enum logic [2:0] {
      kind_write     = 3'd0,                 // Forward on rxwr
      kind_read      = 3'd1,                 // Forward on rxrd
      kind_resp      = 3'd2,                 // Forward on rxrr
      kind_reg_write = 3'd3,                 // Local register write
      kind_reg_read  = 3'd4,                 // Local register read
      kind_drop      = 3'd5                  // Discard
   } kind_t;

endpackage

`default_nettype wire

/* src/erx_regmap_pkg.sv */
`default_nettype none

package erx_regmap_pkg;

   localparam logic [3:0] REG_SPACE = 4'hF;  // Tag in dstaddr[19:16]

   // Offsets within the register space, dstaddr[7:0]
   localparam logic [7:0] REG_CFG           = 8'h00;  // Remap mode
   localparam logic [7:0] REG_REMAP_SEL     = 8'h04;  // Static remap mask
   localparam logic [7:0] REG_REMAP_PATTERN = 8'h08;  // Static remap value
   localparam logic [7:0] REG_REMAP_BASE    = 8'h0C;  // Dynamic remap offset
   localparam logic [7:0] REG_MAILBOX       = 8'h10;  // Push on write, pop on read
   localparam logic [7:0] REG_STATUS        = 8'h14;  // Read only

   // REG_STATUS flag positions
   localparam int STATUS_FULL_BIT      = 8;
   localparam int STATUS_NOT_EMPTY_BIT = 9;

   typedef enum logic [1:0] {
      remap_none    = 2'd0,                  // Address untouched
      remap_static  = 2'd1,                  // Bitwise replace of [31:20]
      remap_dynamic = 2'd2,                  // Add remap_base
      remap_rsvd    = 2'd3                   // Same as remap_none
   } remap_mode_t;

endpackage

`default_nettype wire

/* src/erx_protocol.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_protocol #(
   parameter logic [11:0] ID = 12'h800
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     rx_access,
   input  logic [emesh_pkg::PW-1:0] rx_packet,
   output logic                     dec_access,
   output emesh_pkg::kind_t         dec_kind,
   output logic [emesh_pkg::PW-1:0] dec_packet
);
   import emesh_pkg::*;
   import erx_regmap_pkg::*;

   logic [DSTADDR_W-1:0] rx_dstaddr;         // Incoming destination
   cmd_t                 rx_cmd;             // Incoming opcode
   logic                 reg_hit;            // Aimed at our registers
   kind_t                rx_kind;            // Classification result

   assign rx_dstaddr = rx_packet[DSTADDR_LSB +: DSTADDR_W];
   assign rx_cmd     = cmd_t'(rx_packet[CMD_LSB +: CMD_W]);

   // Our ID on top, register tag just below
   assign reg_hit = (rx_dstaddr[31:20] == ID) && (rx_dstaddr[19:16] == REG_SPACE);

   always_comb begin
      case (rx_cmd)
         cmd_write: rx_kind = reg_hit ? kind_reg_write : kind_write;
         cmd_read:  rx_kind = reg_hit ? kind_reg_read : kind_read;
         cmd_resp:  rx_kind = kind_resp;    // Responses never hit registers
         default:   rx_kind = kind_drop;    // cmd_rsvd
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         dec_access <= 1'b0;
      end else begin
         dec_access <= rx_access;            // Link input stage
      end
   end

   // Payload stage, qualified by dec_access
   always_ff @(posedge clk) begin
      dec_kind   <= rx_kind;
      dec_packet <= rx_packet;
   end

endmodule

`default_nettype wire

/* src/erx_remap.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_remap (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         dec_access,
   input  emesh_pkg::kind_t             dec_kind,
   input  logic [emesh_pkg::PW-1:0]     dec_packet,
   input  erx_regmap_pkg::remap_mode_t  remap_mode,
   input  logic [11:0]                  remap_sel,
   input  logic [11:0]                  remap_pattern,
   input  logic [31:0]                  remap_base,
   output logic                         rmp_access,
   output emesh_pkg::kind_t             rmp_kind,
   output logic [emesh_pkg::PW-1:0]     rmp_packet,
   output logic [31:0]                  rmp_dstaddr
);
   import emesh_pkg::*;
   import erx_regmap_pkg::*;

   logic [31:0] dec_dstaddr;                 // Original address
   logic [31:0] static_addr;                 // Masked top bits
   logic [31:0] dynamic_addr;                // Base-offset address
   logic [31:0] next_dstaddr;                // Chosen by mode

   assign dec_dstaddr = dec_packet[DSTADDR_LSB +: DSTADDR_W];

   // Selected bits take the pattern, rest pass
   assign static_addr = {(remap_sel & remap_pattern) | (~remap_sel & dec_dstaddr[31:20]),
                         dec_dstaddr[19:0]};
   assign dynamic_addr = dec_dstaddr + remap_base;   // Wraps mod 2^32

   always_comb begin
      case (remap_mode)
         remap_static:  next_dstaddr = static_addr;
         remap_dynamic: next_dstaddr = dynamic_addr;
         default:       next_dstaddr = dec_dstaddr;  // None and reserved
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rmp_access <= 1'b0;
      end else begin
         rmp_access <= dec_access;
      end
   end

   // Original packet kept beside new address
   always_ff @(posedge clk) begin
      rmp_kind    <= dec_kind;
      rmp_packet  <= dec_packet;
      rmp_dstaddr <= next_dstaddr;
   end

endmodule

`default_nettype wire

/* src/erx_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_cfg #(
   parameter int MAILBOX_DEPTH = 8
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              reg_we,
   input  logic                              reg_re,
   input  logic [7:0]                        reg_addr,
   input  logic [31:0]                       reg_wdata,
   input  logic [31:0]                       mbx_rdata,
   input  logic [$clog2(MAILBOX_DEPTH):0]    mbx_count,
   output logic [31:0]                       reg_rdata,
   output erx_regmap_pkg::remap_mode_t       remap_mode,
   output logic [11:0]                       remap_sel,
   output logic [11:0]                       remap_pattern,
   output logic [31:0]                       remap_base,
   output logic                              mbx_push,
   output logic                              mbx_pop,
   output logic [31:0]                       mbx_wdata
);
   import erx_regmap_pkg::*;

   localparam int CW = $clog2(MAILBOX_DEPTH) + 1;  // Count width

   logic        mbx_hit;                     // Access at mailbox offset
   logic [31:0] status_word;                 // REG_STATUS contents

   assign mbx_hit   = (reg_addr == REG_MAILBOX);
   assign mbx_push  = reg_we && mbx_hit;     // Write pushes
   assign mbx_pop   = reg_re && mbx_hit;     // Read pops head
   assign mbx_wdata = reg_wdata;

   always_comb begin
      status_word = '0;
      status_word[CW-1:0] = mbx_count;
      status_word[STATUS_FULL_BIT] = (mbx_count == CW'(MAILBOX_DEPTH));
      status_word[STATUS_NOT_EMPTY_BIT] = (mbx_count != '0);
   end

   // Config registers, unknown offsets ignored
   always_ff @(posedge clk) begin
      if (reset) begin
         remap_mode    <= remap_none;
         remap_sel     <= '0;
         remap_pattern <= '0;
         remap_base    <= '0;
      end else if (reg_we) begin
         case (reg_addr)
            REG_CFG:           remap_mode    <= remap_mode_t'(reg_wdata[1:0]);
            REG_REMAP_SEL:     remap_sel     <= reg_wdata[11:0];
            REG_REMAP_PATTERN: remap_pattern <= reg_wdata[11:0];
            REG_REMAP_BASE:    remap_base    <= reg_wdata;
            default: ;                       // Mailbox, status, holes
         endcase
      end
   end

   // Same-cycle read data
   always_comb begin
      reg_rdata = '0;
      case (reg_addr)
         REG_CFG:           reg_rdata[1:0]  = remap_mode;
         REG_REMAP_SEL:     reg_rdata[11:0] = remap_sel;
         REG_REMAP_PATTERN: reg_rdata[11:0] = remap_pattern;
         REG_REMAP_BASE:    reg_rdata       = remap_base;
         REG_MAILBOX:       reg_rdata       = mbx_rdata;  // Zero when empty
         REG_STATUS:        reg_rdata       = status_word;
         default: ;                          // Holes read zero
      endcase
   end

endmodule

`default_nettype wire

/* src/erx_mailbox.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_mailbox #(
   parameter int MAILBOX_DEPTH = 8
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            mbx_push,
   input  logic                            mbx_pop,
   input  logic [31:0]                     mbx_wdata,
   output logic [31:0]                     mbx_rdata,
   output logic [$clog2(MAILBOX_DEPTH):0]  mbx_count,
   output logic                            mailbox_full,
   output logic                            mailbox_not_empty
);
   localparam int AW = $clog2(MAILBOX_DEPTH);  // Pointer width
   localparam int CW = AW + 1;                 // Count width

   logic [31:0]   mem [MAILBOX_DEPTH];         // Word storage
   logic [AW-1:0] wr_ptr;                      // Next free slot
   logic [AW-1:0] rd_ptr;                      // Head slot
   logic          push_ok;                     // Push accepted
   logic          pop_ok;                      // Pop accepted

   assign mailbox_full      = (mbx_count == CW'(MAILBOX_DEPTH));
   assign mailbox_not_empty = (mbx_count != '0);
   assign push_ok = mbx_push && !mailbox_full;    // Lost when full
   assign pop_ok  = mbx_pop && mailbox_not_empty; // No-op when empty

   // Head word, zero when nothing stored
   assign mbx_rdata = mailbox_not_empty ? mem[rd_ptr] : '0;

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         mbx_count <= '0;
      end else begin
         if (push_ok) begin
            wr_ptr <= wr_ptr + 1'b1;         // Wraps at power of two
         end
         if (pop_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         mbx_count <= mbx_count + CW'(push_ok) - CW'(pop_ok);
      end
   end

   always_ff @(posedge clk) begin
      if (push_ok) begin
         mem[wr_ptr] <= mbx_wdata;
      end
   end

endmodule

`default_nettype wire

/* src/erx_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_arbiter (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     rmp_access,
   input  emesh_pkg::kind_t         rmp_kind,
   input  logic [emesh_pkg::PW-1:0] rmp_packet,
   input  logic [31:0]              rmp_dstaddr,
   input  logic [31:0]              reg_rdata,
   output logic                     reg_we,
   output logic                     reg_re,
   output logic [7:0]               reg_addr,
   output logic [31:0]              reg_wdata,
   output logic                     rxwr_access,
   output logic [emesh_pkg::PW-1:0] rxwr_packet,
   output logic                     rxrd_access,
   output logic [emesh_pkg::PW-1:0] rxrd_packet,
   output logic                     rxrr_access,
   output logic [emesh_pkg::PW-1:0] rxrr_packet
);
   import emesh_pkg::*;

   typedef enum logic {
      rsp_idle,                              // No register read outstanding
      rsp_pending                            // Response goes out next edge
   } rsp_state_t;

   rsp_state_t      rsp_state;
   logic [PW-1:0]   req_packet;              // Held register request
   logic [PW-1:0]   fwd_packet;              // Packet with remapped address
   logic [PW-1:0]   rsp_packet;              // Built read response
   logic            reg_access;              // Register kind this cycle

   assign reg_access = rmp_access && (rmp_kind == kind_reg_write || rmp_kind == kind_reg_read);
   assign reg_re     = (rsp_state == rsp_pending);
   assign reg_addr   = req_packet[DSTADDR_LSB +: 8];
   assign reg_wdata  = req_packet[DATA_LSB +: DATA_W];

   always_comb begin
      fwd_packet = rmp_packet;
      fwd_packet[DSTADDR_LSB +: DSTADDR_W] = rmp_dstaddr;
   end

   // Addresses swap, modes copied, data from registers
   always_comb begin
      rsp_packet = '0;
      rsp_packet[CMD_LSB +: CMD_W] = cmd_resp;
      rsp_packet[DATAMODE_LSB +: DATAMODE_W] = req_packet[DATAMODE_LSB +: DATAMODE_W];
      rsp_packet[CTRLMODE_LSB +: CTRLMODE_W] = req_packet[CTRLMODE_LSB +: CTRLMODE_W];
      rsp_packet[DSTADDR_LSB +: DSTADDR_W]   = req_packet[SRCADDR_LSB +: SRCADDR_W];
      rsp_packet[SRCADDR_LSB +: SRCADDR_W]   = req_packet[DSTADDR_LSB +: DSTADDR_W];
      rsp_packet[DATA_LSB +: DATA_W]         = reg_rdata;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rsp_state   <= rsp_idle;
         reg_we      <= 1'b0;
         rxwr_access <= 1'b0;
         rxrd_access <= 1'b0;
         rxrr_access <= 1'b0;
      end else begin
         rsp_state   <= (rmp_access && rmp_kind == kind_reg_read) ? rsp_pending : rsp_idle;
         reg_we      <= rmp_access && (rmp_kind == kind_reg_write);
         rxwr_access <= rmp_access && (rmp_kind == kind_write);
         rxrd_access <= rmp_access && (rmp_kind == kind_read);
         // Pending response owns rxrr, colliding resp lost
         rxrr_access <= reg_re || (rmp_access && rmp_kind == kind_resp);
      end
   end

   always_ff @(posedge clk) begin
      if (reg_access) begin
         req_packet <= rmp_packet;           // Original address for registers
      end
      if (rmp_access) begin
         rxwr_packet <= fwd_packet;
         rxrd_packet <= fwd_packet;
      end
      if (reg_re) begin
         rxrr_packet <= rsp_packet;
      end else if (rmp_access) begin
         rxrr_packet <= rmp_packet;          // Responses not remapped
      end
   end

endmodule

`default_nettype wire

/* src/erx_core.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_core #(
   parameter logic [11:0] ID            = 12'h800,
   parameter int          MAILBOX_DEPTH = 8
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     rx_access,
   input  logic [emesh_pkg::PW-1:0] rx_packet,
   output logic                     rxwr_access,
   output logic [emesh_pkg::PW-1:0] rxwr_packet,
   output logic                     rxrd_access,
   output logic [emesh_pkg::PW-1:0] rxrd_packet,
   output logic                     rxrr_access,
   output logic [emesh_pkg::PW-1:0] rxrr_packet,
   output logic                     mailbox_full,
   output logic                     mailbox_not_empty
);
   import emesh_pkg::*;
   import erx_regmap_pkg::*;

   // Decode stage
   logic          dec_access;
   kind_t         dec_kind;
   logic [PW-1:0] dec_packet;

   // Remap stage
   logic          rmp_access;
   kind_t         rmp_kind;
   logic [PW-1:0] rmp_packet;
   logic [31:0]   rmp_dstaddr;

   // Register access from arbiter
   logic          reg_we;
   logic          reg_re;
   logic [7:0]    reg_addr;
   logic [31:0]   reg_wdata;
   logic [31:0]   reg_rdata;

   // Remap settings
   remap_mode_t   remap_mode;
   logic [11:0]   remap_sel;
   logic [11:0]   remap_pattern;
   logic [31:0]   remap_base;

   // Mailbox side
   logic                           mbx_push;
   logic                           mbx_pop;
   logic [31:0]                    mbx_wdata;
   logic [31:0]                    mbx_rdata;
   logic [$clog2(MAILBOX_DEPTH):0] mbx_count;

   erx_protocol #(.ID(ID)) erx_protocol_inst (
      .clk(clk), .reset(reset),
      .rx_access(rx_access), .rx_packet(rx_packet),
      .dec_access(dec_access), .dec_kind(dec_kind), .dec_packet(dec_packet)
   );

   erx_remap erx_remap_inst (
      .clk(clk), .reset(reset),
      .dec_access(dec_access), .dec_kind(dec_kind), .dec_packet(dec_packet),
      .remap_mode(remap_mode), .remap_sel(remap_sel),
      .remap_pattern(remap_pattern), .remap_base(remap_base),
      .rmp_access(rmp_access), .rmp_kind(rmp_kind),
      .rmp_packet(rmp_packet), .rmp_dstaddr(rmp_dstaddr)
   );

   erx_cfg #(.MAILBOX_DEPTH(MAILBOX_DEPTH)) erx_cfg_inst (
      .clk(clk), .reset(reset),
      .reg_we(reg_we), .reg_re(reg_re), .reg_addr(reg_addr),
      .reg_wdata(reg_wdata), .mbx_rdata(mbx_rdata), .mbx_count(mbx_count),
      .reg_rdata(reg_rdata), .remap_mode(remap_mode), .remap_sel(remap_sel),
      .remap_pattern(remap_pattern), .remap_base(remap_base),
      .mbx_push(mbx_push), .mbx_pop(mbx_pop), .mbx_wdata(mbx_wdata)
   );

   erx_mailbox #(.MAILBOX_DEPTH(MAILBOX_DEPTH)) erx_mailbox_inst (
      .clk(clk), .reset(reset),
      .mbx_push(mbx_push), .mbx_pop(mbx_pop), .mbx_wdata(mbx_wdata),
      .mbx_rdata(mbx_rdata), .mbx_count(mbx_count),
      .mailbox_full(mailbox_full), .mailbox_not_empty(mailbox_not_empty)
   );

   erx_arbiter erx_arbiter_inst (
      .clk(clk), .reset(reset),
      .rmp_access(rmp_access), .rmp_kind(rmp_kind),
      .rmp_packet(rmp_packet), .rmp_dstaddr(rmp_dstaddr), .reg_rdata(reg_rdata),
      .reg_we(reg_we), .reg_re(reg_re), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
      .rxwr_access(rxwr_access), .rxwr_packet(rxwr_packet),
      .rxrd_access(rxrd_access), .rxrd_packet(rxrd_packet),
      .rxrr_access(rxrr_access), .rxrr_packet(rxrr_packet)
   );

endmodule

`default_nettype wire

/* bench/erx_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_core_tb;
   import emesh_pkg::*;
   import erx_regmap_pkg::*;

   localparam logic [11:0] CORE_ID = 12'h800;
   localparam int DEPTH   = 4;               // Mailbox words
   localparam int CH_NONE = -1;
   localparam int CH_WR   = 0;
   localparam int CH_RD   = 1;
   localparam int CH_RR   = 2;

   logic          clk;
   logic          reset;
   logic          rx_access;
   logic [PW-1:0] rx_packet;
   logic          rxwr_access;
   logic [PW-1:0] rxwr_packet;
   logic          rxrd_access;
   logic [PW-1:0] rxrd_packet;
   logic          rxrr_access;
   logic [PW-1:0] rxrr_packet;
   logic          mailbox_full;
   logic          mailbox_not_empty;

   int            cyc = 0;                   // Rising edges seen
   int            sent_count = 0;            // Packets driven so far
   int            errors = 0;
   int            checks = 0;
   logic [31:0]   rng_state;
   int            i;

   // Expected strobes in due order, at most one per cycle
   int            exp_due[$];
   int            exp_chan[$];
   logic [PW-1:0] exp_pkt[$];
   int            now_chan;
   int            now_due;
   logic [PW-1:0] now_pkt;

   // Model of register file and mailbox
   logic [1:0]    m_mode;
   logic [11:0]   m_sel;
   logic [11:0]   m_pat;
   logic [31:0]   m_base;
   logic [31:0]   m_mbx[$];

   erx_core #(.ID(CORE_ID), .MAILBOX_DEPTH(DEPTH)) erx_core_inst (
      .clk(clk), .reset(reset),
      .rx_access(rx_access), .rx_packet(rx_packet),
      .rxwr_access(rxwr_access), .rxwr_packet(rxwr_packet),
      .rxrd_access(rxrd_access), .rxrd_packet(rxrd_packet),
      .rxrr_access(rxrr_access), .rxrr_packet(rxrr_packet),
      .mailbox_full(mailbox_full), .mailbox_not_empty(mailbox_not_empty)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;                    // 100 ns period

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);   // xorshift32
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Expected forwarded address under current model mode
   function automatic logic [31:0] remap_addr(input logic [31:0] addr);
      logic [31:0] res;
      res = addr;
      if (m_mode == 2'd1) begin
         for (int b = 0; b < 12; b++) begin
            if (m_sel[b]) begin
               res[20 + b] = m_pat[b];       // Selected top bit replaced
            end
         end
      end else if (m_mode == 2'd2) begin
         res = addr + m_base;                // Wraps at 32 bits
      end
      return res;
   endfunction

   function automatic logic [PW-1:0] build_packet(input logic [1:0] cmd,
                                                  input logic [31:0] dst,
                                                  input logic [31:0] data);
      logic [31:0] r;
      r = next_random();
      return {next_random(), data, dst, r[3:0], r[5:4], cmd};
   endfunction

   function automatic void write_model(input logic [7:0] off, input logic [31:0] val);
      case (off)
         REG_CFG:           m_mode = val[1:0];
         REG_REMAP_SEL:     m_sel  = val[11:0];
         REG_REMAP_PATTERN: m_pat  = val[11:0];
         REG_REMAP_BASE:    m_base = val;
         REG_MAILBOX: begin
            if (m_mbx.size() < DEPTH) begin
               m_mbx.push_back(val);         // Lost when full
            end
         end
         default: ;
      endcase
   endfunction

   function automatic logic [31:0] read_model(input logic [7:0] off);
      logic [31:0] val;
      val = '0;
      case (off)
         REG_CFG:           val[1:0]  = m_mode;
         REG_REMAP_SEL:     val[11:0] = m_sel;
         REG_REMAP_PATTERN: val[11:0] = m_pat;
         REG_REMAP_BASE:    val       = m_base;
         REG_MAILBOX: begin
            if (m_mbx.size() > 0) begin
               val = m_mbx.pop_front();      // Empty pop reads zero
            end
         end
         REG_STATUS: begin
            val[7:0] = m_mbx.size();
            val[8]   = (m_mbx.size() == DEPTH);
            val[9]   = (m_mbx.size() != 0);
         end
         default: ;
      endcase
      return val;
   endfunction

   function automatic void push_expect(input int due, input int chan, input logic [PW-1:0] pkt);
      exp_due.push_back(due);
      exp_chan.push_back(chan);
      exp_pkt.push_back(pkt);
   endfunction

   // Model updated before the packet is driven
   task automatic send_packet(input logic [PW-1:0] pkt);
      logic [1:0]    cmd;
      logic [31:0]   dst;
      logic [31:0]   src;
      logic [31:0]   val;
      logic          is_reg;
      logic [PW-1:0] fwd;
      cmd    = pkt[CMD_LSB +: CMD_W];
      dst    = pkt[DSTADDR_LSB +: DSTADDR_W];
      src    = pkt[SRCADDR_LSB +: SRCADDR_W];
      is_reg = (dst[31:20] == CORE_ID) && (dst[19:16] == REG_SPACE);
      case (cmd)
         cmd_resp: push_expect(cyc + 3, CH_RR, pkt);
         cmd_rsvd: ;                         // Dropped
         default: begin
            if (is_reg && cmd == cmd_write) begin
               write_model(dst[7:0], pkt[DATA_LSB +: DATA_W]);
            end else if (is_reg) begin
               val = read_model(dst[7:0]);
               // Response with swapped addresses and copied modes
               push_expect(cyc + 4, CH_RR, {dst, val, src, pkt[7:2], 2'b10});
            end else begin
               fwd = pkt;
               fwd[DSTADDR_LSB +: DSTADDR_W] = remap_addr(dst);
               push_expect(cyc + 3, (cmd == cmd_write) ? CH_WR : CH_RD, fwd);
            end
         end
      endcase
      rx_access  = 1'b1;
      rx_packet  = pkt;
      sent_count = sent_count + 1;
      @(posedge clk);
      #1;
      rx_access = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // Register access followed by a settling gap
   task automatic reg_access(input logic [1:0] cmd, input logic [7:0] off,
                             input logic [31:0] data);
      send_packet(build_packet(cmd, {CORE_ID, REG_SPACE, 8'h00, off}, data));
      idle_cycles(4);
   endtask

   // Back-to-back packets outside the register space
   task automatic random_traffic(input int n);
      logic [31:0] r;
      logic [31:0] dst;
      repeat (n) begin
         r   = next_random();
         dst = next_random();
         if (dst[31:20] == CORE_ID) begin
            dst[20] = 1'b1;                  // Steer off our ID
         end
         send_packet(build_packet(r[1:0], dst, next_random()));
      end
   endtask

   task automatic check_flags();
      checks = checks + 2;
      assert (mailbox_full == (m_mbx.size() == DEPTH)) else begin
         errors = errors + 1;
         $display("CHECK FAILED mailbox_full: got %h, expected %h",
                  mailbox_full, (m_mbx.size() == DEPTH));
      end
      assert (mailbox_not_empty == (m_mbx.size() != 0)) else begin
         errors = errors + 1;
         $display("CHECK FAILED mailbox_not_empty: got %h, expected %h",
                  mailbox_not_empty, (m_mbx.size() != 0));
      end
   endtask

   task automatic check_channel(input int chan, input string name, input logic acc,
                                input logic [PW-1:0] pkt);
      if (now_chan == chan) begin
         checks = checks + 1;
         assert (acc) else begin
            errors = errors + 1;
            $display("Expected strobe on %s did not come at cycle %0d", name, now_due);
         end
         if (acc) begin
            assert (pkt == now_pkt) else begin
               errors = errors + 1;
               $display("CHECK FAILED %s_packet: got %h, expected %h", name, pkt, now_pkt);
            end
         end
      end else begin
         assert (!acc) else begin
            errors = errors + 1;
            $display("Unexpected strobe on %s at cycle %0d", name, cyc);
         end
      end
   endtask

   // Compare at the falling edge where outputs are stable
   always @(negedge clk) begin
      if (!reset) begin
         now_chan = CH_NONE;
         if (exp_due.size() > 0 && exp_due[0] == cyc) begin
            now_due  = exp_due.pop_front();
            now_chan = exp_chan.pop_front();
            now_pkt  = exp_pkt.pop_front();
         end
         check_channel(CH_WR, "rxwr", rxwr_access, rxwr_packet);
         check_channel(CH_RD, "rxrd", rxrd_access, rxrd_packet);
         check_channel(CH_RR, "rxrr", rxrr_access, rxrr_packet);
      end
   end

   // Watchdog budget grows with packets sent
   initial begin
      @(posedge clk);
      while (cyc <= sent_count * 10 + 200) @(posedge clk);
      $display("Timeout: run stopped after %0d cycles without finishing", cyc);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      reset     = 1'b1;
      rx_access = 1'b0;
      rx_packet = '0;
      rng_state = 32'd42;
      m_mode    = '0;
      m_sel     = '0;
      m_pat     = '0;
      m_base    = '0;
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;

      random_traffic(40);                    // remap_none with all opcodes

      reg_access(cmd_write, REG_REMAP_SEL, next_random());
      reg_access(cmd_write, REG_REMAP_PATTERN, next_random());
      reg_access(cmd_write, REG_CFG, 32'd1);  // Static mode
      random_traffic(20);

      reg_access(cmd_write, REG_REMAP_BASE, next_random());
      reg_access(cmd_write, REG_CFG, 32'd2);  // Dynamic mode
      random_traffic(20);

      // Read-back of every register and holes
      reg_access(cmd_read, REG_CFG, 32'd0);
      reg_access(cmd_read, REG_REMAP_SEL, 32'd0);
      reg_access(cmd_read, REG_REMAP_PATTERN, 32'd0);
      reg_access(cmd_read, REG_REMAP_BASE, 32'd0);
      reg_access(cmd_read, REG_STATUS, 32'd0);
      reg_access(cmd_write, 8'h24, next_random());
      reg_access(cmd_read, 8'h24, 32'd0);
      reg_access(cmd_write, REG_CFG, 32'd3);  // Reserved mode acts as none
      reg_access(cmd_read, REG_CFG, 32'd0);
      random_traffic(10);

      // Mailbox filled past full and drained past empty
      check_flags();
      for (i = 0; i < DEPTH + 1; i++) begin
         reg_access(cmd_write, REG_MAILBOX, next_random());
         check_flags();
         reg_access(cmd_read, REG_STATUS, 32'd0);
      end
      for (i = 0; i < DEPTH + 1; i++) begin
         reg_access(cmd_read, REG_MAILBOX, 32'd0);
         check_flags();
         reg_access(cmd_read, REG_STATUS, 32'd0);
      end

      while (exp_due.size() != 0) @(posedge clk);
      idle_cycles(5);                        // Catch late extra strobes
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* erx_core.f */
src/emesh_pkg.sv
src/erx_regmap_pkg.sv
src/erx_protocol.sv
src/erx_remap.sv
src/erx_cfg.sv
src/erx_mailbox.sv
src/erx_arbiter.sv
src/erx_core.sv
bench/erx_core_tb.sv
